/* include/fpc_defs.svh */
// register file reset value and instruction bundle width macros
`ifndef FPC_DEFS_SVH
`define FPC_DEFS_SVH

// every architectural register comes out of reset holding zero
`define FPC_REG_RESET 32'h0000_0000

// opcode (3) + rd, rs1, rs2 (3 x 5) + immediate (32)
// keep in step with the widths in fpc_pkg
`define FPC_INSTR_W 50

`endif

/* source/fpc_pkg.sv */
// shared data and register index widths and the opcode enum
`default_nettype none

package fpc_pkg;

  // integer datapath width
  localparam int unsigned xlen_p = 32;

  // register index width and register count
  localparam int unsigned reg_addr_w_p = 5;
  localparam int unsigned num_regs_p = 32;

  // offloaded register-to-register operations
  // LI takes no source register, MOV reads rs1 only
  // the arithmetic ops read both rs1 and rs2
  typedef enum logic [2:0] {
    OP_LI  = 3'd0,
    OP_ADD = 3'd1,
    OP_SUB = 3'd2,
    // low 32 bits of the product only
    OP_MUL = 3'd3,
    OP_MOV = 3'd4
  } opcode_e;

endpackage

`default_nettype wire

/* source/fpc_instr_buffer.sv */
// credit-fed circular instruction buffer with occupancy count and credit return pulse
`timescale 1ns/1ps
`default_nettype none
`include "fpc_defs.svh"

module fpc_instr_buffer
  import fpc_pkg::*;
#(
  parameter int unsigned BUF_DEPTH = 4
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // offload port from the core
  input  wire logic                    instr_valid_i,
  input  wire opcode_e                 instr_op_i,
  input  wire logic [reg_addr_w_p-1:0] instr_rd_i,
  input  wire logic [reg_addr_w_p-1:0] instr_rs1_i,
  input  wire logic [reg_addr_w_p-1:0] instr_rs2_i,
  input  wire logic [xlen_p-1:0]       instr_imm_i,
  // pop request from the controller
  input  wire logic                    pop_i,
  // oldest entry
  output logic                         head_valid_o,
  output opcode_e                      head_op_o,
  output logic [reg_addr_w_p-1:0]      head_rd_o,
  output logic [reg_addr_w_p-1:0]      head_rs1_o,
  output logic [reg_addr_w_p-1:0]      head_rs2_o,
  output logic [xlen_p-1:0]            head_imm_o,
  output logic                         credit_return_o
);

  // a depth of one still needs a one bit pointer
  localparam int unsigned PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(BUF_DEPTH + 1);

  // field positions inside one stored entry
  localparam int unsigned RS2_LSB = xlen_p;
  localparam int unsigned RS1_LSB = RS2_LSB + reg_addr_w_p;
  localparam int unsigned RD_LSB = RS1_LSB + reg_addr_w_p;
  localparam int unsigned OP_LSB = RD_LSB + reg_addr_w_p;

  logic [`FPC_INSTR_W-1:0] mem_q [BUF_DEPTH];
  logic [`FPC_INSTR_W-1:0] wr_entry;
  logic [`FPC_INSTR_W-1:0] head_entry;
  logic [PTR_W-1:0]        wptr_q;
  logic [PTR_W-1:0]        rptr_q;
  logic [CNT_W-1:0]        count_q;
  logic                    pop_acc;

  // pointer increment with wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(BUF_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // pack the decoded fields, opcode on top
  assign wr_entry = {instr_op_i, instr_rd_i, instr_rs1_i, instr_rs2_i, instr_imm_i};

  // head is read straight from storage so it is visible the cycle after the write
  assign head_entry   = mem_q[rptr_q];
  assign head_valid_o = (count_q != '0);
  assign head_op_o    = opcode_e'(head_entry[OP_LSB +: $bits(opcode_e)]);
  assign head_rd_o    = head_entry[RD_LSB +: reg_addr_w_p];
  assign head_rs1_o   = head_entry[RS1_LSB +: reg_addr_w_p];
  assign head_rs2_o   = head_entry[RS2_LSB +: reg_addr_w_p];
  assign head_imm_o   = head_entry[xlen_p-1:0];

  // a pop only counts when there is something to pop
  assign pop_acc = pop_i & head_valid_o;
  // one credit back per popped entry, same cycle
  assign credit_return_o = pop_acc;

  // storage, the core never sends without a credit so no full check
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      mem_q[wptr_q] <= wr_entry;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (instr_valid_i) begin
        wptr_q <= next_ptr(wptr_q);
      end
      if (pop_acc) begin
        rptr_q <= next_ptr(rptr_q);
      end
      // push and pop together leave the count unchanged
      if (instr_valid_i && !pop_acc) begin
        count_q <= count_q + 1'b1;
      end else if (!instr_valid_i && pop_acc) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/fpc_controller.sv */
// in-order issue controller with destination scoreboard, hazard checks and forwarding select
`timescale 1ns/1ps
`default_nettype none

module fpc_controller
  import fpc_pkg::*;
#(
  parameter bit FORWARDING = 1'b1
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // buffer head
  input  wire logic                    head_valid_i,
  input  wire opcode_e                 head_op_i,
  input  wire logic [reg_addr_w_p-1:0] head_rd_i,
  input  wire logic [reg_addr_w_p-1:0] head_rs1_i,
  input  wire logic [reg_addr_w_p-1:0] head_rs2_i,
  // writeback bus from the execution pipe
  input  wire logic                    wb_valid_i,
  input  wire logic [reg_addr_w_p-1:0] wb_rd_i,
  // issue control
  output logic                         issue_valid_o,
  output logic                         pop_o,
  // bit 0 bypasses rs1, bit 1 bypasses rs2
  output logic [1:0]                   fwd_sel_o
);

  // one pending-write bit per register
  logic [num_regs_p-1:0] rd_scoreboard_d;
  logic [num_regs_p-1:0] rd_scoreboard_q;

  // operand usage decoded from the opcode
  logic uses_rs1;
  logic uses_rs2;

  // writeback this cycle targets the named register
  logic wb_hit_rs1;
  logic wb_hit_rs2;
  logic wb_hit_rd;

  // dependencies left after forwarding
  logic dep_rs1;
  logic dep_rs2;
  logic dep_rd;

  // LI has no source, MOV only rs1
  always_comb begin
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    unique case (head_op_i)
      OP_LI: begin
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
      end
      OP_MOV: begin
        uses_rs1 = 1'b1;
      end
      OP_ADD, OP_SUB, OP_MUL: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      default: begin
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
      end
    endcase
  end

  // without forwarding a writeback never clears a hazard early
  // so the stall ends the cycle after, once the register file holds the value
  assign wb_hit_rs1 = FORWARDING & wb_valid_i & (wb_rd_i == head_rs1_i);
  assign wb_hit_rs2 = FORWARDING & wb_valid_i & (wb_rd_i == head_rs2_i);
  assign wb_hit_rd  = FORWARDING & wb_valid_i & (wb_rd_i == head_rd_i);

  // bypass the writeback data into the operand reads
  assign fwd_sel_o[0] = head_valid_i & uses_rs1 & wb_hit_rs1;
  assign fwd_sel_o[1] = head_valid_i & uses_rs2 & wb_hit_rs2;

  // read after write on either source
  assign dep_rs1 = rd_scoreboard_q[head_rs1_i] & uses_rs1 & ~fwd_sel_o[0];
  assign dep_rs2 = rd_scoreboard_q[head_rs2_i] & uses_rs2 & ~fwd_sel_o[1];

  // write after write, a retiring older write frees the destination
  // since the new result lands LATENCY cycles later
  assign dep_rd = rd_scoreboard_q[head_rd_i] & ~wb_hit_rd;

  // issue the head whenever it is clear, every issue pops
  assign issue_valid_o = head_valid_i & ~dep_rs1 & ~dep_rs2 & ~dep_rd;
  assign pop_o         = issue_valid_o;

  // clear on writeback first, then set on issue
  // so an issue to the retiring rd keeps its bit set
  always_comb begin
    rd_scoreboard_d = rd_scoreboard_q;
    if (wb_valid_i) begin
      rd_scoreboard_d[wb_rd_i] = 1'b0;
    end
    if (issue_valid_o) begin
      rd_scoreboard_d[head_rd_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_scoreboard_q <= '0;
    end else begin
      rd_scoreboard_q <= rd_scoreboard_d;
    end
  end

endmodule

`default_nettype wire

/* source/fpc_exec_pipe.sv */
// fixed-latency integer execution pipeline carrying destination tags
`timescale 1ns/1ps
`default_nettype none

module fpc_exec_pipe
  import fpc_pkg::*;
#(
  parameter int unsigned LATENCY = 3
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // issued instruction with its operand values
  input  wire logic                    issue_valid_i,
  input  wire opcode_e                 op_i,
  input  wire logic [reg_addr_w_p-1:0] rd_i,
  input  wire logic [xlen_p-1:0]       opa_i,
  input  wire logic [xlen_p-1:0]       opb_i,
  input  wire logic [xlen_p-1:0]       imm_i,
  // writeback bus, LATENCY cycles after issue
  output logic                         res_valid_o,
  output logic [reg_addr_w_p-1:0]      res_rd_o,
  output logic [xlen_p-1:0]            res_data_o
);

  // stage 0 is loaded at the end of the issue cycle
  logic                    valid_q [LATENCY];
  logic [reg_addr_w_p-1:0] rd_q    [LATENCY];
  logic [xlen_p-1:0]       data_q  [LATENCY];

  logic [xlen_p-1:0]       result;

  // stage 1 arithmetic
  always_comb begin
    unique case (op_i)
      OP_LI:   result = imm_i;
      OP_ADD:  result = opa_i + opb_i;
      OP_SUB:  result = opa_i - opb_i;
      // 32 bit context keeps the low half of the product
      OP_MUL:  result = opa_i * opb_i;
      OP_MOV:  result = opa_i;
      default: result = '0;
    endcase
  end

  // valid flags, one per stage
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < LATENCY; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else begin
      valid_q[0] <= issue_valid_i;
      for (int i = 1; i < LATENCY; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // tag and data shift along with the valid flag
  always_ff @(posedge clk_i) begin
    rd_q[0]   <= rd_i;
    data_q[0] <= result;
    for (int i = 1; i < LATENCY; i++) begin
      rd_q[i]   <= rd_q[i-1];
      data_q[i] <= data_q[i-1];
    end
  end

  // last stage drives the writeback bus
  assign res_valid_o = valid_q[LATENCY-1];
  assign res_rd_o    = rd_q[LATENCY-1];
  assign res_data_o  = data_q[LATENCY-1];

endmodule

`default_nettype wire

/* source/fpc_regfile.sv */
// 32-entry register file with two operand read ports, one write port and bypass muxes
`timescale 1ns/1ps
`default_nettype none
`include "fpc_defs.svh"

module fpc_regfile
  import fpc_pkg::*;
(
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // writeback port
  input  wire logic                    we_i,
  input  wire logic [reg_addr_w_p-1:0] waddr_i,
  input  wire logic [xlen_p-1:0]       wdata_i,
  // operand read ports
  input  wire logic [reg_addr_w_p-1:0] raddr1_i,
  input  wire logic [reg_addr_w_p-1:0] raddr2_i,
  // per-port bypass of the writeback data
  input  wire logic [1:0]              fwd_sel_i,
  output logic [xlen_p-1:0]            rdata1_o,
  output logic [xlen_p-1:0]            rdata2_o
);

  logic [xlen_p-1:0] regs_q [num_regs_p];

  // write lands at the end of the writeback cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < num_regs_p; i++) begin
        regs_q[i] <= `FPC_REG_RESET;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // a read in the same cycle as the write sees the old value
  // unless the bypass is selected
  always_comb begin
    if (fwd_sel_i[0]) begin
      rdata1_o = wdata_i;
    end else begin
      rdata1_o = regs_q[raddr1_i];
    end
  end

  always_comb begin
    if (fwd_sel_i[1]) begin
      rdata2_o = wdata_i;
    end else begin
      rdata2_o = regs_q[raddr2_i];
    end
  end

endmodule

`default_nettype wire

/* source/fpc_top.sv */
// coprocessor top level with instruction buffer, issue controller, register file and pipe
`timescale 1ns/1ps
`default_nettype none

module fpc_top
  import fpc_pkg::*;
#(
  parameter int unsigned BUF_DEPTH  = 4,
  parameter int unsigned LATENCY    = 3,
  parameter bit          FORWARDING = 1'b1
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // offload port from the core
  input  wire logic                    instr_valid_i,
  input  wire opcode_e                 instr_op_i,
  input  wire logic [reg_addr_w_p-1:0] instr_rd_i,
  input  wire logic [reg_addr_w_p-1:0] instr_rs1_i,
  input  wire logic [reg_addr_w_p-1:0] instr_rs2_i,
  input  wire logic [xlen_p-1:0]       instr_imm_i,
  // one pulse per freed buffer entry
  output logic                         credit_return_o,
  // result report to the core, also the register file write
  output logic                         wb_valid_o,
  output logic [reg_addr_w_p-1:0]      wb_rd_o,
  output logic [xlen_p-1:0]            wb_data_o
);

  // buffer head
  logic                    head_valid;
  opcode_e                 head_op;
  logic [reg_addr_w_p-1:0] head_rd;
  logic [reg_addr_w_p-1:0] head_rs1;
  logic [reg_addr_w_p-1:0] head_rs2;
  logic [xlen_p-1:0]       head_imm;

  // controller outputs
  logic                    pop;
  logic                    issue_valid;
  logic [1:0]              fwd_sel;

  // operand values into the pipe
  logic [xlen_p-1:0]       opa;
  logic [xlen_p-1:0]       opb;

  fpc_instr_buffer #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_instr_buffer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .instr_valid_i   (instr_valid_i),
    .instr_op_i      (instr_op_i),
    .instr_rd_i      (instr_rd_i),
    .instr_rs1_i     (instr_rs1_i),
    .instr_rs2_i     (instr_rs2_i),
    .instr_imm_i     (instr_imm_i),
    .pop_i           (pop),
    .head_valid_o    (head_valid),
    .head_op_o       (head_op),
    .head_rd_o       (head_rd),
    .head_rs1_o      (head_rs1),
    .head_rs2_o      (head_rs2),
    .head_imm_o      (head_imm),
    .credit_return_o (credit_return_o)
  );

  fpc_controller #(
    .FORWARDING (FORWARDING)
  ) u_controller (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .head_valid_i  (head_valid),
    .head_op_i     (head_op),
    .head_rd_i     (head_rd),
    .head_rs1_i    (head_rs1),
    .head_rs2_i    (head_rs2),
    .wb_valid_i    (wb_valid_o),
    .wb_rd_i       (wb_rd_o),
    .issue_valid_o (issue_valid),
    .pop_o         (pop),
    .fwd_sel_o     (fwd_sel)
  );

  // source addresses come straight from the buffer head
  fpc_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .we_i      (wb_valid_o),
    .waddr_i   (wb_rd_o),
    .wdata_i   (wb_data_o),
    .raddr1_i  (head_rs1),
    .raddr2_i  (head_rs2),
    .fwd_sel_i (fwd_sel),
    .rdata1_o  (opa),
    .rdata2_o  (opb)
  );

  fpc_exec_pipe #(
    .LATENCY (LATENCY)
  ) u_exec_pipe (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_valid_i (issue_valid),
    .op_i          (head_op),
    .rd_i          (head_rd),
    .opa_i         (opa),
    .opb_i         (opb),
    .imm_i         (head_imm),
    .res_valid_o   (wb_valid_o),
    .res_rd_o      (wb_rd_o),
    .res_data_o    (wb_data_o)
  );

endmodule

`default_nettype wire

/* bench/fpc_tb.sv */
// testbench for fpc_top with stimulus table, reference model, writeback monitor and report
`timescale 1ns/1ps
`default_nettype none
`include "fpc_defs.svh"

module fpc_tb
  import fpc_pkg::*;
;

  localparam int BUF_DEPTH = 4;
  localparam int LATENCY = 3;
  localparam bit FORWARDING = 1'b1;
  localparam int TIMEOUT = 200;
  localparam int NUM_VECS = 21;
  localparam int NUM_RAND = 40;

  // one offloaded instruction and the result it should produce
  typedef struct packed {
    logic [3:0]  test;
    opcode_e     op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic [31:0] exp;
  } vec_t;

  // test, op, rd, rs1, rs2, imm, expected rd value
  vec_t vec_tbl [NUM_VECS] = '{
    // dependent chain
    '{4'd2, OP_LI,  5'd1,  5'd0,  5'd0,  32'd5,          32'd5},
    '{4'd2, OP_LI,  5'd2,  5'd0,  5'd0,  32'd7,          32'd7},
    '{4'd2, OP_ADD, 5'd3,  5'd1,  5'd2,  32'd0,          32'd12},
    '{4'd2, OP_SUB, 5'd4,  5'd3,  5'd1,  32'd0,          32'd7},
    '{4'd2, OP_MUL, 5'd5,  5'd4,  5'd3,  32'd0,          32'd84},
    '{4'd2, OP_MOV, 5'd6,  5'd5,  5'd0,  32'd0,          32'd84},
    '{4'd2, OP_ADD, 5'd3,  5'd3,  5'd6,  32'd0,          32'd96},
    '{4'd2, OP_MUL, 5'd3,  5'd3,  5'd3,  32'd0,          32'd9216},
    '{4'd2, OP_LI,  5'd7,  5'd0,  5'd0,  32'hffff_fff0,  32'hffff_fff0},
    '{4'd2, OP_MUL, 5'd8,  5'd7,  5'd2,  32'd0,          32'hffff_ff90},
    '{4'd2, OP_SUB, 5'd9,  5'd1,  5'd2,  32'd0,          32'hffff_fffe},
    // MUL waits on r10 and ADD on r11 so the LIs behind them fill the buffer
    '{4'd3, OP_LI,  5'd10, 5'd0,  5'd0,  32'd3,          32'd3},
    '{4'd3, OP_MUL, 5'd11, 5'd10, 5'd10, 32'd0,          32'd9},
    '{4'd3, OP_ADD, 5'd12, 5'd11, 5'd10, 32'd0,          32'd12},
    '{4'd3, OP_LI,  5'd13, 5'd0,  5'd0,  32'h13,         32'h13},
    '{4'd3, OP_LI,  5'd14, 5'd0,  5'd0,  32'h14,         32'h14},
    '{4'd3, OP_LI,  5'd15, 5'd0,  5'd0,  32'h15,         32'h15},
    '{4'd3, OP_LI,  5'd16, 5'd0,  5'd0,  32'h16,         32'h16},
    // two writes to r20, then read it back
    '{4'd4, OP_LI,  5'd20, 5'd0,  5'd0,  32'h1111,       32'h1111},
    '{4'd4, OP_MUL, 5'd20, 5'd2,  5'd2,  32'd0,          32'd49},
    '{4'd4, OP_MOV, 5'd21, 5'd20, 5'd0,  32'd0,          32'd49}
  };

  logic        clk_i;
  logic        rst_ni;
  logic        instr_valid_i;
  opcode_e     instr_op_i;
  logic [4:0]  instr_rd_i;
  logic [4:0]  instr_rs1_i;
  logic [4:0]  instr_rs2_i;
  logic [31:0] instr_imm_i;
  logic        credit_return_o;
  logic        wb_valid_o;
  logic [4:0]  wb_rd_o;
  logic [31:0] wb_data_o;

  // reference register state, in program order
  logic [31:0] model_regs [32];
  logic [4:0]  exp_rd_q [$];
  logic [31:0] exp_data_q [$];

  int sent_cnt = 0;
  int ret_cnt = 0;
  int wb_cnt = 0;
  int max_out = 0;
  int err_cnt = 0;
  int check_cnt = 0;
  int test_cnt = 0;

  fpc_top #(
    .BUF_DEPTH  (BUF_DEPTH),
    .LATENCY    (LATENCY),
    .FORWARDING (FORWARDING)
  ) u_fpc_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .instr_valid_i   (instr_valid_i),
    .instr_op_i      (instr_op_i),
    .instr_rd_i      (instr_rd_i),
    .instr_rs1_i     (instr_rs1_i),
    .instr_rs2_i     (instr_rs2_i),
    .instr_imm_i     (instr_imm_i),
    .credit_return_o (credit_return_o),
    .wb_valid_o      (wb_valid_o),
    .wb_rd_o         (wb_rd_o),
    .wb_data_o       (wb_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      $display("ERROR: t=%0t %s: got %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // result of one instruction by the opcode rules
  function automatic logic [31:0] model_result(input vec_t v);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    a = model_regs[v.rs1];
    b = model_regs[v.rs2];
    case (v.op)
      OP_LI:   r = v.imm;
      OP_ADD:  r = a + b;
      OP_SUB:  r = a - b;
      OP_MUL:  r = a * b;
      OP_MOV:  r = a;
      default: r = '0;
    endcase
    return r;
  endfunction

  // spend one credit, waiting for one if none is left
  task automatic send_instr(input vec_t v, input bit has_exp);
    int waited;
    logic [31:0] res;
    waited = 0;
    while ((sent_cnt - ret_cnt) >= BUF_DEPTH && waited < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if ((sent_cnt - ret_cnt) >= BUF_DEPTH) begin
      $display("no credit came back within %0d cycles at t=%0t", TIMEOUT, $time);
      err_cnt++;
      return;
    end
    instr_valid_i = 1'b1;
    instr_op_i    = v.op;
    instr_rd_i    = v.rd;
    instr_rs1_i   = v.rs1;
    instr_rs2_i   = v.rs2;
    instr_imm_i   = v.imm;
    res = model_result(v);
    model_regs[v.rd] = res;
    exp_rd_q.push_back(v.rd);
    exp_data_q.push_back(res);
    if (has_exp) begin
      check_eq(res, v.exp, "table value against model");
    end
    sent_cnt++;
    @(posedge clk_i);
    #1;
    instr_valid_i = 1'b0;
  endtask

  // all expected results written back
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_rd_q.size() != 0 && waited < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (exp_rd_q.size() != 0) begin
      $display("pipeline did not drain within %0d cycles at t=%0t", TIMEOUT, $time);
      err_cnt++;
    end
  endtask

  task automatic report_test(input int num, input string name, input int err0);
    test_cnt++;
    $display("test %0d %s: %0d errors", num, name, err_cnt - err0);
  endtask

  // writeback and credit monitor, sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (credit_return_o) begin
        ret_cnt++;
      end
      if (sent_cnt - ret_cnt > max_out) begin
        max_out = sent_cnt - ret_cnt;
      end
      if (wb_valid_o) begin
        wb_cnt++;
        if (exp_rd_q.size() == 0) begin
          $display("ERROR: t=%0t writeback to r%0d with nothing pending", $time, wb_rd_o);
          err_cnt++;
        end else begin
          check_eq(32'(wb_rd_o), 32'(exp_rd_q.pop_front()), "writeback rd");
          check_eq(wb_data_o, exp_data_q.pop_front(), "writeback data");
        end
      end
    end
  end

  initial begin
    int err0;
    int wb0;
    int gap;
    vec_t rv;
    void'($urandom(32'h7117d3ce));
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_op_i    = OP_LI;
    instr_rd_i    = '0;
    instr_rs1_i   = '0;
    instr_rs2_i   = '0;
    instr_imm_i   = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = `FPC_REG_RESET;
    end
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // quiet outputs after reset
    err0 = err_cnt;
    repeat (10) begin
      @(negedge clk_i);
      check_eq(32'(wb_valid_o), 32'd0, "wb_valid_o after reset");
      check_eq(32'(credit_return_o), 32'd0, "credit_return_o after reset");
    end
    @(posedge clk_i);
    #1;
    report_test(1, "reset idle", err0);

    // directed tests from the table
    for (int t = 2; t <= 4; t++) begin
      err0 = err_cnt;
      max_out = 0;
      for (int i = 0; i < NUM_VECS; i++) begin
        if (vec_tbl[i].test == 4'(t)) begin
          send_instr(vec_tbl[i], 1'b1);
        end
      end
      wait_drain();
      if (t == 2) begin
        report_test(2, "dependent chain", err0);
      end else if (t == 3) begin
        check_eq(32'(ret_cnt), 32'(sent_cnt), "credits returned");
        check_eq(32'(max_out), 32'(BUF_DEPTH), "peak outstanding");
        report_test(3, "buffer fill", err0);
      end else begin
        report_test(4, "write after write", err0);
      end
    end

    // random ops over r0 to r7 with idle gaps
    err0 = err_cnt;
    wb0 = wb_cnt;
    for (int n = 0; n < NUM_RAND; n++) begin
      rv.test = 4'd5;
      rv.op   = opcode_e'(3'($urandom_range(4, 0)));
      rv.rd   = 5'($urandom_range(7, 0));
      rv.rs1  = 5'($urandom_range(7, 0));
      rv.rs2  = 5'($urandom_range(7, 0));
      rv.imm  = $urandom();
      rv.exp  = '0;
      send_instr(rv, 1'b0);
      gap = int'($urandom_range(3, 0));
      repeat (gap) begin
        @(posedge clk_i);
        #1;
      end
    end
    wait_drain();
    check_eq(32'(wb_cnt - wb0), 32'(NUM_RAND), "random writeback count");
    report_test(5, "random mix", err0);

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
source/fpc_pkg.sv
source/fpc_instr_buffer.sv
source/fpc_controller.sv
source/fpc_exec_pipe.sv
source/fpc_regfile.sv
source/fpc_top.sv
bench/fpc_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the coprocessor testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f project.f --top-module fpc_tb --Mdir obj_dir -o fpc_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/fpc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
  exit 1
fi
if ! grep -q "PASS: all tests" "$LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
